//--- vlog.f
+incdir+include
source/rv_ctrl_pkg.sv
source/inst_decoder.sv
source/pc_target_unit.sv
source/fetch_wb_master.sv
source/ctrl_fsm.sv
source/rv_ctrl_top.sv
sim/tb_clock_gen.sv
sim/rv_ctrl_tb.sv

//--- Makefile
# Verilator flow for the RV32I control path testbench
# Any variable can be overridden on the command line

VERILATOR  ?= verilator
FILELIST   ?= vlog.f
TOP        ?= rv_ctrl_tb
BUILD_DIR  ?= obj_dir
BUILD_ARGS ?= --binary --timing -j 0
LINT_ARGS  ?= --lint-only --timing
PASS_TEXT  ?= Finished with no errors
SOURCES    := $(wildcard include/*.svh source/*.sv sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_ARGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_ARGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- sim/rv_ctrl_tb.sv
// Testbench of the RV32I control path with a Wishbone instruction memory and a register model
// Runs a random program up to a planted EBREAK and checks every fetch address and register write
`timescale 1ns/1ps

`include "rv_ctrl_consts.svh"

module rv_ctrl_tb
    import rv_ctrl_pkg::*;
();

    localparam int    WAIT_LIMIT  = 64;
    localparam int    HALT_WATCH  = 200;
    localparam word_t EBREAK_WORD = 32'h0010_0073;

    logic        aclk;
    logic        aresetn;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    word_t       wb_adr;
    word_t       wb_dat;
    logic        wb_ack;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    word_t       rs1_val;
    word_t       rs2_val;
    logic        rd_wr;
    reg_addr_t   rd_addr;
    word_t       rd_val;
    logic        halted;

    // Instruction memory indexed by address bits 9:2
    word_t       imem [256];
    // Register file model
    word_t       regs [32];
    // Wait states left for the slave (-1 while idle)
    int          wait_left;
    int unsigned ack_delay;

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(8)) clock_gen (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    rv_ctrl_top UUT (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat   (wb_dat),
        .wb_ack   (wb_ack),
        .rs1_addr (rs1_addr),
        .rs1_val  (rs1_val),
        .rs2_addr (rs2_addr),
        .rs2_val  (rs2_val),
        .rd_wr    (rd_wr),
        .rd_addr  (rd_addr),
        .rd_val   (rd_val),
        .halted   (halted)
    );

    //////////////////////////////
    // Register file and bus slave
    //////////////////////////////

    // Same-cycle read
    assign rs1_val = regs[rs1_addr];
    assign rs2_val = regs[rs2_addr];

    // Writes to x0 are dropped so it stays zero
    always @(posedge aclk) begin
        if (aresetn && rd_wr && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_val;
        end
    end

    // Wishbone classic slave with 0 to 3 wait cycles per strobe
    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wb_ack    <= 1'b0;
            wait_left <= -1;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (wait_left == 0) begin
                    wb_ack    <= 1'b1;
                    wb_dat    <= imem[wb_adr[9:2]];
                    wait_left <= -1;
                end else if (wait_left > 0) begin
                    wait_left <= wait_left - 1;
                end else begin
                    // Fresh strobe
                    ack_delay = $urandom % 4;
                    if (ack_delay == 0) begin
                        wb_ack <= 1'b1;
                        wb_dat <= imem[wb_adr[9:2]];
                    end else begin
                        wait_left <= int'(ack_delay) - 1;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // Stimulus and reference
    //////////////////////////////

    function automatic word_t random_instruction();
        word_t       ins;
        int unsigned f3;
        ins = $urandom;
        case ($urandom % 8)
            0: ins[6:0] = 7'b0110111;
            1: ins[6:0] = 7'b0010111;
            // Jump offsets kept word aligned
            2: begin
                ins[6:0] = 7'b1101111;
                ins[21]  = 1'b0;
            end
            3: begin
                ins[6:0]   = 7'b1100111;
                ins[14:12] = 3'b000;
                ins[21:20] = 2'b00;
            end
            4, 5: begin
                ins[6:0] = 7'b1100011;
                ins[8]   = 1'b0;
                f3       = $urandom % 7;
                // Six conditions plus reserved code 2
                if (f3 < 2) begin
                    ins[14:12] = 3'(f3);
                end else if (f3 < 6) begin
                    ins[14:12] = 3'(f3 + 2);
                end else begin
                    ins[14:12] = 3'b010;
                end
                // Same source register now and then so that equality shows up
                if ($urandom % 4 == 0) begin
                    ins[24:20] = ins[19:15];
                end
            end
            6: begin
                case ($urandom % 5)
                    0: ins[6:0] = 7'b0010011;
                    1: ins[6:0] = 7'b0110011;
                    2: ins[6:0] = 7'b0000011;
                    3: ins[6:0] = 7'b0100011;
                    default: ins[6:0] = 7'b0001111;
                endcase
            end
            // ECALL as a SYSTEM word that is not EBREAK
            default: ins = 32'h0000_0073;
        endcase
        return ins;
    endfunction

    // Expected next fetch and write-back of one instruction
    function automatic void reference_step(
        input  word_t     pc,
        input  word_t     ins,
        input  word_t     a,
        input  word_t     b,
        output word_t     npc,
        output logic      wr,
        output reg_addr_t rd,
        output word_t     val
    );
        word_t imm_i;
        word_t imm_b;
        word_t imm_j;
        word_t imm_u;
        logic  taken;
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        imm_u = {ins[31:12], 12'h000};
        case (ins[14:12])
            3'b000: taken = (a == b);
            3'b001: taken = (a != b);
            3'b100: taken = ($signed(a) < $signed(b));
            3'b101: taken = ($signed(a) >= $signed(b));
            3'b110: taken = (a < b);
            3'b111: taken = (a >= b);
            default: taken = 1'b0;
        endcase
        npc = pc + `RV_INST_STEP;
        val = pc + `RV_INST_STEP;
        wr  = 1'b0;
        rd  = ins[11:7];
        case (ins[6:0])
            // LUI
            7'b0110111: begin
                val = imm_u;
                wr  = 1'b1;
            end
            // AUIPC
            7'b0010111: begin
                val = pc + imm_u;
                wr  = 1'b1;
            end
            // JAL
            7'b1101111: begin
                npc = pc + imm_j;
                wr  = 1'b1;
            end
            // JALR clears bit 0 of the target
            7'b1100111: begin
                npc = (a + imm_i) & ~32'h1;
                wr  = 1'b1;
            end
            7'b1100011: begin
                if (taken) begin
                    npc = pc + imm_b;
                end
            end
            default: begin
            end
        endcase
    endfunction

    //////////////////////////////
    // Checks and waits
    //////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            report_failure($sformatf("Error in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            report_failure($sformatf("Error in %s: expected x%0d, actual x%0d", name, exp, act));
        end
    endtask

    task automatic expect_low(input string what, input logic value);
        if (value !== 1'b0) begin
            report_failure({what, " is not low"});
        end
    endtask

    task automatic wait_for_strobe(input string name);
        int n;
        n = 0;
        while (wb_stb !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                report_failure({"Timeout waiting for the fetch strobe of ", name});
            end
            @(negedge aclk);
            n++;
        end
    endtask

    // Address must not move while the slave holds off
    task automatic wait_for_ack(input string name, input word_t addr);
        int n;
        n = 0;
        check_word(name, addr, wb_adr);
        while (wb_ack !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                report_failure({"Timeout waiting for the slave to acknowledge ", name});
            end
            @(negedge aclk);
            n++;
            if (wb_cyc !== 1'b1 || wb_stb !== 1'b1) begin
                report_failure({"Strobe dropped before acknowledge of ", name});
            end
            check_word({name, " held"}, addr, wb_adr);
        end
    endtask

    // Watches the register ports from the ack up to the next strobe or the halt
    task automatic watch_writeback(input string name, input logic exp_wr,
                                   input reg_addr_t exp_rd, input word_t exp_val,
                                   input reg_addr_t exp_rs1, input reg_addr_t exp_rs2);
        int n;
        int writes;
        n      = 0;
        writes = 0;
        @(negedge aclk);
        while (wb_stb !== 1'b1 && halted !== 1'b1) begin
            // Source indexes follow the held instruction
            check_reg_addr({name, " rs1"}, exp_rs1, rs1_addr);
            check_reg_addr({name, " rs2"}, exp_rs2, rs2_addr);
            if (rd_wr === 1'b1) begin
                if (!exp_wr) begin
                    report_failure({"Register write issued by a non-writing ", name});
                end
                check_reg_addr({name, " destination"}, exp_rd, rd_addr);
                check_word({name, " write value"}, exp_val, rd_val);
                writes++;
            end
            if (n == WAIT_LIMIT) begin
                report_failure({"Timeout waiting for the next fetch after ", name});
            end
            @(negedge aclk);
            n++;
        end
        if (exp_wr && writes != 1) begin
            report_failure({"Register write missing or repeated for ", name});
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int        i;
        int        k;
        int        n;
        int        depth;
        word_t     pc_exp;
        word_t     ins;
        word_t     npc;
        logic      wr;
        reg_addr_t rd;
        word_t     val;
        string     name;
        void'($urandom(32'hc639_17a2));
        wb_ack <= 1'b0;
        wb_dat <= '0;
        for (i = 0; i < 256; i++) begin
            imem[i] = random_instruction();
        end
        // Aligned start values keep every JALR target aligned
        regs[0] <= '0;
        for (i = 1; i < 32; i++) begin
            regs[i] <= $urandom & 32'hffff_fffc;
        end
        depth = 150 + int'($urandom % 100);

        // Bus, write and halt quiet through reset and the boot cycle
        n = 0;
        while (aresetn !== 1'b1) begin
            @(negedge aclk);
            expect_low("wb_cyc around reset", wb_cyc);
            expect_low("wb_stb around reset", wb_stb);
            expect_low("rd_wr around reset", rd_wr);
            expect_low("halted around reset", halted);
            n++;
            if (n == WAIT_LIMIT) begin
                report_failure("Timeout waiting for reset release");
            end
        end

        pc_exp = `RV_BOOT_ADDR;
        for (k = 0; k <= depth; k++) begin
            name = $sformatf("instruction %0d at %h", k, pc_exp);
            wait_for_strobe(name);
            expect_low("wb_we", wb_we);
            // EBREAK planted where the program has got to
            if (k == depth) begin
                imem[pc_exp[9:2]] = EBREAK_WORD;
            end
            ins = imem[pc_exp[9:2]];
            reference_step(pc_exp, ins, regs[ins[19:15]], regs[ins[24:20]], npc, wr, rd, val);
            wait_for_ack({name, " fetch address"}, pc_exp);
            watch_writeback(name, wr, rd, val, ins[19:15], ins[24:20]);
            if (k < depth && halted === 1'b1) begin
                report_failure({"Core halted without EBREAK after ", name});
            end
            pc_exp = npc;
        end

        // No more fetches once halted
        for (n = 0; n < HALT_WATCH; n++) begin
            @(negedge aclk);
            if (halted !== 1'b1) begin
                report_failure("halted is not high after EBREAK");
            end
            expect_low("wb_stb after halt", wb_stb);
            expect_low("wb_cyc after halt", wb_cyc);
            expect_low("rd_wr after halt", rd_wr);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- sim/tb_clock_gen.sv
// Clock and reset source of the testbench
// Free-running clock, reset held low for a fixed number of rising edges
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) aclk = ~aclk;
        end
    end

    // Release lands on a rising edge, so the DUT sees it one cycle later
    initial begin
        aresetn <= 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;
    end

endmodule

//--- source/rv_ctrl_top.sv
// Top level of the RV32I control path
// Connects the fetch master, decoder, target unit and control FSM
`timescale 1ns/1ps

module rv_ctrl_top
    import rv_ctrl_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    // Wishbone classic instruction read
    output logic      wb_cyc,
    output logic      wb_stb,
    output logic      wb_we,
    output word_t     wb_adr,
    input  word_t     wb_dat,
    input  logic      wb_ack,
    // Register file read, answered in the same cycle
    output reg_addr_t rs1_addr,
    input  word_t     rs1_val,
    output reg_addr_t rs2_addr,
    input  word_t     rs2_val,
    // Register file write
    output logic      rd_wr,
    output reg_addr_t rd_addr,
    output word_t     rd_val,
    // Core stopped by EBREAK
    output logic      halted
);

    // FSM to fetch master handshake
    logic         fetch_req;
    word_t        fetch_addr;
    logic         fetch_done;
    word_t        instruction;

    // Decoded fields
    opcode_e      opcode;
    branch_cond_e cond;
    word_t        imm_i;
    word_t        imm_b;
    word_t        imm_j;
    word_t        imm_u;
    logic         is_ebreak;

    // Target unit results
    word_t        pc;
    word_t        next_pc;
    logic         rd_wr_op;

    fetch_wb_master fetch_master (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .wb_dat      (wb_dat),
        .wb_ack      (wb_ack),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .fetch_done  (fetch_done),
        .instruction (instruction)
    );

    inst_decoder decoder (
        .instruction (instruction),
        .opcode      (opcode),
        .cond        (cond),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rd_addr     (rd_addr),
        .imm_i       (imm_i),
        .imm_b       (imm_b),
        .imm_j       (imm_j),
        .imm_u       (imm_u),
        .is_ebreak   (is_ebreak)
    );

    pc_target_unit target_unit (
        .pc       (pc),
        .opcode   (opcode),
        .cond     (cond),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .imm_i    (imm_i),
        .imm_b    (imm_b),
        .imm_j    (imm_j),
        .imm_u    (imm_u),
        .next_pc  (next_pc),
        .rd_val   (rd_val),
        .rd_wr_op (rd_wr_op)
    );

    ctrl_fsm control (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .fetch_done (fetch_done),
        .next_pc    (next_pc),
        .rd_wr_op   (rd_wr_op),
        .is_ebreak  (is_ebreak),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .pc         (pc),
        .rd_wr      (rd_wr),
        .halted     (halted)
    );

endmodule

//--- source/ctrl_fsm.sv
// Control FSM of the core, owns the program counter
// Sequences fetch and execute, issues register writes and stops on EBREAK
`timescale 1ns/1ps

`include "rv_ctrl_consts.svh"

module ctrl_fsm
    import rv_ctrl_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  fetch_done,
    input  word_t next_pc,
    input  logic  rd_wr_op,
    input  logic  is_ebreak,
    output logic  fetch_req,
    output word_t fetch_addr,
    output word_t pc,
    output logic  rd_wr,
    output logic  halted
);

    ctrl_state_e state;

    // The fetch always targets the current program counter
    assign fetch_addr = pc;

    // Register write only during the single execute cycle
    assign rd_wr = (state == EXECUTE) & rd_wr_op;

    // Stays high until the next reset
    assign halted = (state == HALT);

    ////////////////////////////////
    // State and program counter
    ////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= BOOT;
            pc        <= `RV_BOOT_ADDR;
            fetch_req <= 1'b0;
        end else begin
            // Request is a single-cycle pulse
            fetch_req <= 1'b0;
            case (state)
                // One idle cycle after reset, then first fetch
                BOOT: begin
                    pc        <= `RV_BOOT_ADDR;
                    fetch_req <= 1'b1;
                    state     <= FETCH;
                end
                // Wait for the word, however many wait states the slave adds
                FETCH: begin
                    if (fetch_done) begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (is_ebreak) begin
                        // PC kept pointing at the EBREAK
                        state <= HALT;
                    end else begin
                        pc        <= next_pc;
                        fetch_req <= 1'b1;
                        state     <= FETCH;
                    end
                end
                // No more requests
                default: begin
                    state <= HALT;
                end
            endcase
        end
    end

endmodule

//--- source/fetch_wb_master.sv
// Wishbone classic read master, one instruction word per fetch request
// Holds the returned word for the decoder until the next fetch completes
`timescale 1ns/1ps

module fetch_wb_master
    import rv_ctrl_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  fetch_req,
    input  word_t fetch_addr,
    input  word_t wb_dat,
    input  logic  wb_ack,
    output logic  wb_cyc,
    output logic  wb_stb,
    output logic  wb_we,
    output word_t wb_adr,
    output logic  fetch_done,
    output word_t instruction
);

    logic req_accept;
    logic ack_seen;

    // A new request is taken only while the bus is idle
    assign req_accept = fetch_req & ~wb_cyc;

    // Slave ends the classic cycle
    assign ack_seen = wb_cyc & wb_ack;

    // Instruction fetch never writes
    assign wb_we = 1'b0;

    ////////////////////////////////
    // Bus cycle control
    ////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wb_cyc     <= 1'b0;
            wb_stb     <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            // Done is high in the cycle right after ack
            fetch_done <= ack_seen;
            if (ack_seen) begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
            end else if (req_accept) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
            end
        end
    end

    // Address held for the whole cycle, word captured on ack
    always_ff @(posedge aclk) begin
        if (req_accept) begin
            wb_adr <= fetch_addr;
        end
        if (ack_seen) begin
            instruction <= wb_dat;
        end
    end

endmodule

//--- source/pc_target_unit.sv
// Next program counter and destination value for one instruction
// Purely combinational, read by the control FSM during its EXECUTE cycle
`timescale 1ns/1ps

`include "rv_ctrl_consts.svh"

module pc_target_unit
    import rv_ctrl_pkg::*;
(
    input  word_t        pc,
    input  opcode_e      opcode,
    input  branch_cond_e cond,
    input  word_t        rs1_val,
    input  word_t        rs2_val,
    input  word_t        imm_i,
    input  word_t        imm_b,
    input  word_t        imm_j,
    input  word_t        imm_u,
    output word_t        next_pc,
    output word_t        rd_val,
    output logic         rd_wr_op
);

    word_t pc_step;
    word_t jalr_sum;
    logic  branch_taken;

    // Sequential address, also the link value of the jumps
    assign pc_step = pc + word_t'(`RV_INST_STEP);

    // JALR target before the LSB is cleared
    assign jalr_sum = rs1_val + imm_i;

    ////////////////////////////////
    // Branch condition
    ////////////////////////////////

    always_comb begin
        case (cond)
            BEQ:     branch_taken = (rs1_val == rs2_val);
            BNE:     branch_taken = (rs1_val != rs2_val);
            // Signed compares
            BLT:     branch_taken = ($signed(rs1_val) < $signed(rs2_val));
            BGE:     branch_taken = ($signed(rs1_val) >= $signed(rs2_val));
            // Unsigned compares
            BLTU:    branch_taken = (rs1_val < rs2_val);
            BGEU:    branch_taken = (rs1_val >= rs2_val);
            // Reserved funct3 never branches
            default: branch_taken = 1'b0;
        endcase
    end

    ////////////////////////////////
    // Target and write-back value
    ////////////////////////////////

    always_comb begin
        // Plain fall-through, nothing written
        next_pc  = pc_step;
        rd_val   = pc_step;
        rd_wr_op = 1'b0;
        case (opcode)
            LUI: begin
                rd_val   = imm_u;
                rd_wr_op = 1'b1;
            end
            AUIPC: begin
                rd_val   = pc + imm_u;
                rd_wr_op = 1'b1;
            end
            JAL: begin
                next_pc  = pc + imm_j;
                rd_wr_op = 1'b1;
            end
            JALR: begin
                next_pc  = {jalr_sum[`RV_XLEN-1:1], 1'b0};
                rd_wr_op = 1'b1;
            end
            BRANCH: begin
                if (branch_taken) begin
                    next_pc = pc + imm_b;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- source/inst_decoder.sv
// Combinational decoder of the held instruction word
// Feeds register indexes to the register file and immediates to the target unit
`timescale 1ns/1ps

`include "rv_ctrl_consts.svh"

module inst_decoder
    import rv_ctrl_pkg::*;
(
    input  word_t        instruction,
    output opcode_e      opcode,
    output branch_cond_e cond,
    output reg_addr_t    rs1_addr,
    output reg_addr_t    rs2_addr,
    output reg_addr_t    rd_addr,
    output word_t        imm_i,
    output word_t        imm_b,
    output word_t        imm_j,
    output word_t        imm_u,
    output logic         is_ebreak
);

    ////////////////////////////////
    // Register fields
    ////////////////////////////////

    // Same bit positions in every format that carries them
    assign rd_addr  = instruction[11:7];
    assign rs1_addr = instruction[19:15];
    assign rs2_addr = instruction[24:20];

    // funct3 passed as is, reserved codes fall out of the enum range
    assign cond = branch_cond_e'(instruction[14:12]);

    ////////////////////////////////
    // Immediates
    ////////////////////////////////

    // I format, sign bit is instruction[31] for all formats
    assign imm_i = {{(`RV_XLEN-`RV_IMM12_W){instruction[31]}}, instruction[31:20]};

    // B format, byte offset with an implicit zero LSB
    assign imm_b = {{(`RV_XLEN-`RV_IMM12_W-1){instruction[31]}}, instruction[31],
                    instruction[7], instruction[30:25], instruction[11:8], 1'b0};

    // J format, same idea over a 20-bit field
    assign imm_j = {{(`RV_XLEN-`RV_IMM20_W-1){instruction[31]}}, instruction[31],
                    instruction[19:12], instruction[20], instruction[30:21], 1'b0};

    // U format, upper 20 bits with the low bits cleared
    assign imm_u = {instruction[31:12], {(`RV_XLEN-`RV_IMM20_W){1'b0}}};

    ////////////////////////////////
    // Opcode class
    ////////////////////////////////

    always_comb begin
        case (instruction[6:0])
            LUI:     opcode = LUI;
            AUIPC:   opcode = AUIPC;
            JAL:     opcode = JAL;
            JALR:    opcode = JALR;
            BRANCH:  opcode = BRANCH;
            SYSTEM:  opcode = SYSTEM;
            // ALU, loads, stores, fences and unknown codes
            default: opcode = OTHER;
        endcase
    end

    // Only the exact EBREAK word halts, other SYSTEM words act as no-ops
    assign is_ebreak = (instruction == 32'h0010_0073);

endmodule

//--- source/rv_ctrl_pkg.sv
// Shared types of the RV32I control path
// Imported by wildcard in every RTL module and in the testbench
`include "rv_ctrl_consts.svh"

package rv_ctrl_pkg;

    // One machine word, used for addresses, instructions and register values
    typedef logic [`RV_XLEN-1:0] word_t;

    // Register file index
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // Major opcodes handled by the control path
    // OTHER is not a legal RV32I opcode and stands for every other class
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011,
        OTHER  = 7'b0000000
    } opcode_e;

    // Branch funct3 encodings, codes 2 and 3 are reserved
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_cond_e;

    // Control FSM states
    typedef enum logic [1:0] {
        BOOT    = 2'd0,
        FETCH   = 2'd1,
        EXECUTE = 2'd2,
        HALT    = 2'd3
    } ctrl_state_e;

endpackage

//--- include/rv_ctrl_consts.svh
// Global constants of the RV32I control path
// Included by the package and by every RTL file that needs a width or an address
`ifndef RV_CTRL_CONSTS_SVH
`define RV_CTRL_CONSTS_SVH

// Data, address and instruction word width
`define RV_XLEN 32

// Register index width, 32 architectural registers
`define RV_REG_ADDR_W 5

// First fetch address after reset
`define RV_BOOT_ADDR 32'h0000_0000

// Byte increment between two sequential instructions
`define RV_INST_STEP 4

// Immediate field widths of the I/B and U/J formats
`define RV_IMM12_W 12
`define RV_IMM20_W 20

`endif
